// ==== axi_pkg.sv ====
package axi_pkg;

    // Fixed AXI4 field widths for this link
    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;

    // One strobe bit per data byte
    localparam int STRB_W = DATA_W / 8;

    // Widths defined by the AXI4 protocol itself
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // Payload field types
    typedef logic [ID_W-1:0]    axi_id_t;
    typedef logic [ADDR_W-1:0]  axi_addr_t;
    typedef logic [DATA_W-1:0]  axi_data_t;
    typedef logic [STRB_W-1:0]  axi_strb_t;

    // Burst control field types
    typedef logic [LEN_W-1:0]   axi_len_t;
    typedef logic [SIZE_W-1:0]  axi_size_t;
    typedef logic [BURST_W-1:0] axi_burst_t;
    typedef logic [RESP_W-1:0]  axi_resp_t;

    // AW or AR request, 49 bits
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        // Beats in burst minus one
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } ax_req_t;

    // W beat, 73 bits
    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        // Final beat of the burst
        logic      last;
    } w_beat_t;

    // B response
    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } b_resp_t;

    // R beat
    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } r_beat_t;

endpackage

// ==== shaper_pkg.sv ====
package shaper_pkg;

    // Token bucket fixed point format, 16.8
    localparam int TOKEN_INT_W  = 16;
    localparam int TOKEN_FRAC_W = 8;

    // Full width of the bucket value
    localparam int TOKEN_W = TOKEN_INT_W + TOKEN_FRAC_W;

    // Rate format, one integer bit over the fraction
    localparam int RATE_W = TOKEN_FRAC_W + 1;

    // Bucket value in 16.8 fixed point
    typedef logic [TOKEN_W-1:0] token_count_t;

    // Initial and idle reload value
    // Integer tokens only, the fraction is implied zero
    typedef logic [TOKEN_INT_W-1:0] token_init_t;

    // Tokens added each cycle in 1.8 fixed point
    // Largest rate is just under two tokens per cycle
    typedef logic [RATE_W-1:0] token_rate_t;

endpackage

// ==== ax_token_shaper.sv ====
`timescale 1ns/1ps

module ax_token_shaper #(
    // Tokens charged per beat of the burst
    parameter int BEAT_COST  = 16,
    // Tokens charged once per request
    parameter int FIXED_COST = 15
) (
    input  logic                    aclk,
    input  logic                    aresetn,

    // Upstream address channel
    input  axi_pkg::ax_req_t        s_req,
    input  logic                    s_valid,
    output logic                    s_ready,

    // Downstream address channel
    output axi_pkg::ax_req_t        m_req,
    output logic                    m_valid,
    input  logic                    m_ready,

    // Bucket configuration
    input  shaper_pkg::token_init_t init_tokens,
    input  shaper_pkg::token_rate_t upd_tokens
);

    // Integer cost width, wide enough for any len and parameter mix
    localparam int COST_W    = 32;
    localparam int COST_FP_W = COST_W + shaper_pkg::TOKEN_FRAC_W;
    // One carry bit above the bucket for saturation
    localparam int SUM_W     = shaper_pkg::TOKEN_W + 1;

    shaper_pkg::token_count_t tokens;
    shaper_pkg::token_count_t tokens_nxt;
    shaper_pkg::token_count_t init_fp;
    shaper_pkg::token_count_t take_fp;
    logic [COST_W-1:0]        cost;
    logic [COST_FP_W-1:0]     cost_fp;
    logic [SUM_W-1:0]         sum;
    logic                     permit;
    logic                     accept;
    logic                     idle;
    logic                     above_init;

    // Cost of the pending request, (len + 1) * beat cost + fixed cost
    assign cost = (COST_W'(s_req.len) + COST_W'(1)) * COST_W'(BEAT_COST)
                  + COST_W'(FIXED_COST);

    // Same cost in bucket fixed point
    assign cost_fp = {cost, {shaper_pkg::TOKEN_FRAC_W{1'b0}}};

    // Request may pass only while the bucket covers it
    assign permit = (cost_fp <= COST_FP_W'(tokens));

    // Zero latency gate, payload untouched
    assign m_req   = s_req;
    assign m_valid = s_valid & permit;
    assign s_ready = m_ready & permit;

    // Handshake completes on the downstream side this cycle
    assign accept = s_valid & m_ready & permit;

    // Cost fits in the bucket width whenever accept is high
    assign take_fp = accept ? cost_fp[shaper_pkg::TOKEN_W-1:0] : '0;

    // Add rate, remove cost of the accepted request
    // take never exceeds tokens, so no borrow out of the top bit
    assign sum = SUM_W'(tokens) + SUM_W'(upd_tokens) - SUM_W'(take_fp);

    // Initial value aligned to the fixed point
    assign init_fp = {init_tokens, {shaper_pkg::TOKEN_FRAC_W{1'b0}}};

    // Downstream could take a request but none is offered
    assign idle       = m_ready & ~s_valid;
    assign above_init = (tokens > init_fp);

    always_comb begin
        if (idle && above_init) begin
            // Idle channel drops excess credit
            tokens_nxt = init_fp;
        end else if (sum[SUM_W-1]) begin
            // Saturate on carry out
            tokens_nxt = '1;
        end else begin
            tokens_nxt = sum[shaper_pkg::TOKEN_W-1:0];
        end
    end

    // Bucket register, starts full at the initial value
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tokens <= init_fp;
        end else begin
            tokens <= tokens_nxt;
        end
    end

endmodule

// ==== write_tracker.sv ====
`timescale 1ns/1ps

module write_tracker #(
    // AWs allowed ahead of their last W beat
    parameter int MAX_OUTSTANDING_WR = 8
) (
    input  logic             aclk,
    input  logic             aresetn,

    // Upstream AW
    input  axi_pkg::ax_req_t s_aw,
    input  logic             s_awvalid,
    output logic             s_awready,

    // AW towards the token shaper
    output axi_pkg::ax_req_t m_aw,
    output logic             m_awvalid,
    input  logic             m_awready,

    // Upstream W
    input  axi_pkg::w_beat_t s_w,
    input  logic             s_wvalid,
    output logic             s_wready,

    // Downstream W
    output axi_pkg::w_beat_t m_w,
    output logic             m_wvalid,
    input  logic             m_wready
);

    // Counter holds 0 up to the limit inclusive
    localparam int CNT_W = $clog2(MAX_OUTSTANDING_WR + 1);

    logic [CNT_W-1:0] outstanding;
    logic             aw_permit;
    logic             w_permit;
    logic             aw_done;
    logic             w_last_done;

    // AW held at the limit, W held until an AW has gone out
    assign aw_permit = (outstanding < CNT_W'(MAX_OUTSTANDING_WR));
    assign w_permit  = (outstanding != '0);

    // AW gate
    assign m_aw      = s_aw;
    assign m_awvalid = s_awvalid & aw_permit;
    assign s_awready = m_awready & aw_permit;

    // W gate
    assign m_w      = s_w;
    assign m_wvalid = s_wvalid & w_permit;
    assign s_wready = m_wready & w_permit;

    // m_awready already carries the shaper permit, so this is the final AW handshake
    assign aw_done = m_awvalid & m_awready;

    // Burst closes on the accepted last beat
    assign w_last_done = m_wvalid & m_wready & s_w.last;

    // Up/down count of open write bursts
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            outstanding <= '0;
        end else begin
            case ({aw_done, w_last_done})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                // Both or neither, count holds
                default: outstanding <= outstanding;
            endcase
        end
    end

endmodule

// ==== axi_bw_shaper.sv ====
`timescale 1ns/1ps

module axi_bw_shaper #(
    parameter int MAX_OUTSTANDING_WR = 8,
    // Cost terms per beat and per request
    parameter int W_TIMEOUT_CYCLES   = 15,
    parameter int B_TIMEOUT_CYCLES   = 15,
    parameter int R_TIMEOUT_CYCLES   = 15
) (
    input  logic                    aclk,
    input  logic                    aresetn,

    // Upstream AW
    input  axi_pkg::ax_req_t        s_aw,
    input  logic                    s_awvalid,
    output logic                    s_awready,

    // Upstream W
    input  axi_pkg::w_beat_t        s_w,
    input  logic                    s_wvalid,
    output logic                    s_wready,

    // Upstream B
    output axi_pkg::b_resp_t        s_b,
    output logic                    s_bvalid,
    input  logic                    s_bready,

    // Upstream AR
    input  axi_pkg::ax_req_t        s_ar,
    input  logic                    s_arvalid,
    output logic                    s_arready,

    // Upstream R
    output axi_pkg::r_beat_t        s_r,
    output logic                    s_rvalid,
    input  logic                    s_rready,

    // Downstream AW
    output axi_pkg::ax_req_t        m_aw,
    output logic                    m_awvalid,
    input  logic                    m_awready,

    // Downstream W
    output axi_pkg::w_beat_t        m_w,
    output logic                    m_wvalid,
    input  logic                    m_wready,

    // Downstream B
    input  axi_pkg::b_resp_t        m_b,
    input  logic                    m_bvalid,
    output logic                    m_bready,

    // Downstream AR
    output axi_pkg::ax_req_t        m_ar,
    output logic                    m_arvalid,
    input  logic                    m_arready,

    // Downstream R
    input  axi_pkg::r_beat_t        m_r,
    input  logic                    m_rvalid,
    output logic                    m_rready,

    // Bucket setup per address channel
    input  shaper_pkg::token_init_t aw_init_tokens,
    input  shaper_pkg::token_init_t ar_init_tokens,
    input  shaper_pkg::token_rate_t aw_upd_tokens,
    input  shaper_pkg::token_rate_t ar_upd_tokens
);

    // AW between tracker and token shaper
    axi_pkg::ax_req_t trk_aw;
    logic             trk_awvalid;
    logic             trk_awready;

    // Outstanding limit on AW, W held until an AW is out
    write_tracker #(
        .MAX_OUTSTANDING_WR (MAX_OUTSTANDING_WR)
    ) wr_trk0 (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .m_aw      (trk_aw),
        .m_awvalid (trk_awvalid),
        .m_awready (trk_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready)
    );

    // Write bucket, charges data beats plus the response wait
    ax_token_shaper #(
        .BEAT_COST  (W_TIMEOUT_CYCLES + 1),
        .FIXED_COST (B_TIMEOUT_CYCLES)
    ) aw_shp0 (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req       (trk_aw),
        .s_valid     (trk_awvalid),
        .s_ready     (trk_awready),
        .m_req       (m_aw),
        .m_valid     (m_awvalid),
        .m_ready     (m_awready),
        .init_tokens (aw_init_tokens),
        .upd_tokens  (aw_upd_tokens)
    );

    // Read bucket, charges read beats only
    ax_token_shaper #(
        .BEAT_COST  (R_TIMEOUT_CYCLES + 1),
        .FIXED_COST (0)
    ) ar_shp0 (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req       (s_ar),
        .s_valid     (s_arvalid),
        .s_ready     (s_arready),
        .m_req       (m_ar),
        .m_valid     (m_arvalid),
        .m_ready     (m_arready),
        .init_tokens (ar_init_tokens),
        .upd_tokens  (ar_upd_tokens)
    );

    // B returns unshaped
    assign s_b      = m_b;
    assign s_bvalid = m_bvalid;
    assign m_bready = s_bready;

    // R returns unshaped
    assign s_r      = m_r;
    assign s_rvalid = m_rvalid;
    assign m_rready = s_rready;

endmodule

// ==== tb_axi_bw_shaper.sv ====
`timescale 1ns/1ps

module tb_axi_bw_shaper;

    // Top level settings that the bucket costs follow from
    localparam int MAX_WR      = 8;
    localparam int T_W         = 15;
    localparam int T_B         = 15;
    localparam int T_R         = 15;
    localparam int AW_BEAT     = T_W + 1;
    localparam int AR_BEAT     = T_R + 1;
    localparam longint TOK_MAX = 64'hFF_FFFF;
    localparam int MAX_TESTS   = 64;

    logic aclk;
    logic aresetn;
    axi_pkg::ax_req_t s_aw, m_aw, s_ar, m_ar;
    axi_pkg::w_beat_t s_w, m_w;
    axi_pkg::b_resp_t s_b, m_b;
    axi_pkg::r_beat_t s_r, m_r;
    logic s_awvalid, s_awready, m_awvalid, m_awready;
    logic s_wvalid, s_wready, m_wvalid, m_wready;
    logic s_bvalid, s_bready, m_bvalid, m_bready;
    logic s_arvalid, s_arready, m_arvalid, m_arready;
    logic s_rvalid, s_rready, m_rvalid, m_rready;
    shaper_pkg::token_init_t aw_init_tokens, ar_init_tokens;
    shaper_pkg::token_rate_t aw_upd_tokens, ar_upd_tokens;

    // Columns are kind chan len nreq init rate window expected
    int tests[MAX_TESTS][8];
    int n_tests;
    int watchdog_ns = 0;
    int cur_kind, cur_chan, cur_len, cur_nreq, cur_window;

    // Reference model and master state
    longint tok_aw, tok_ar, cost_sum;
    int outst, w_beat, burst_beats, issued, acc_cnt;
    int wq[$];
    logic req_on, w_fresh;
    int mism_errs, other_errs;

    axi_bw_shaper #(
        .MAX_OUTSTANDING_WR (MAX_WR),
        .W_TIMEOUT_CYCLES   (T_W),
        .B_TIMEOUT_CYCLES   (T_B),
        .R_TIMEOUT_CYCLES   (T_R)
    ) dut0 (.*);

    // 4 ns clock
    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    // Bucket rule for one cycle in 16.8 fixed point
    function automatic longint bucket_step(input longint tok, input longint init_fp,
                                           input longint rate, input logic req,
                                           input logic rdy, input longint take_fp);
        longint nxt;
        nxt = tok + rate - take_fp;
        if (nxt > TOK_MAX) begin
            nxt = TOK_MAX;
        end
        // Idle channel drops credit above the initial value
        if (rdy && !req && tok > init_fp) begin
            nxt = init_fp;
        end
        return nxt;
    endfunction

    function automatic axi_pkg::ax_req_t rand_req(input int len);
        axi_pkg::ax_req_t r;
        r.id    = $urandom;
        r.addr  = $urandom;
        r.len   = len;
        r.size  = $urandom;
        r.burst = $urandom;
        return r;
    endfunction

    task automatic check_val(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
        assert (act === exp) else begin
            mism_errs++;
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic drive_idle();
        s_aw      = '0;
        s_awvalid = 1'b0;
        s_w       = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        s_ar      = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        m_awready = 1'b1;
        m_wready  = 1'b1;
        m_b       = '0;
        m_bvalid  = 1'b0;
        m_arready = 1'b1;
        m_r       = '0;
        m_rvalid  = 1'b0;
    endtask

    // Entered on a falling edge and returns on the edge that releases reset
    task automatic apply_reset();
        aresetn = 1'b0;
        drive_idle();
        tok_ar      = longint'(ar_init_tokens) * 256;
        tok_aw      = longint'(aw_init_tokens) * 256;
        outst       = 0;
        wq.delete();
        w_beat      = 0;
        burst_beats = 0;
        issued      = 0;
        acc_cnt     = 0;
        cost_sum    = 0;
        req_on      = 1'b0;
        w_fresh     = 1'b1;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    endtask

    // Drive on the falling edge, check 1 ns later, model the coming rising edge
    task automatic step_cycle(input int cyc);
        logic ar_perm, aw_room, aw_perm, w_perm, aw_fwd, ar_take, aw_take, w_end;
        longint ar_cost, aw_cost;
        // Slave ready patterns
        m_arready = (cur_kind == 1) ? (($urandom % 2) != 0) : 1'b1;
        m_awready = (cur_kind == 1) ? (($urandom % 2) != 0) : 1'b1;
        m_wready  = (cur_kind == 1) ? (($urandom % 2) != 0) : 1'b1;
        if (cur_kind == 2) begin
            m_wready = (cyc >= cur_window / 2);
        end
        // Next request once the previous one has gone
        if (!req_on && issued < cur_nreq) begin
            req_on = 1'b1;
            issued++;
            if (cur_chan == 0) begin
                s_ar = rand_req(cur_len);
            end else begin
                s_aw = rand_req(cur_len);
                // W data offered right away ahead of its AW
                wq.push_back(cur_len);
            end
        end
        s_arvalid = req_on && (cur_chan == 0);
        s_awvalid = req_on && (cur_chan == 1);
        if (w_fresh) begin
            s_w.data = {$urandom, $urandom};
            s_w.strb = $urandom;
            w_fresh  = 1'b0;
        end
        s_wvalid = (wq.size() != 0);
        s_w.last = 1'b0;
        if (wq.size() != 0) begin
            s_w.last = (w_beat == wq[0]);
        end
        // B and R sources hold until taken
        if (!m_bvalid || s_bready) begin
            m_bvalid = ($urandom % 2) != 0;
            m_b      = $urandom;
        end
        if (!m_rvalid || s_rready) begin
            m_rvalid = ($urandom % 2) != 0;
            m_r      = {$urandom, $urandom, $urandom};
        end
        s_bready = ($urandom % 2) != 0;
        s_rready = ($urandom % 2) != 0;
        #1;
        ar_cost = (longint'(s_ar.len) + 1) * AR_BEAT;
        aw_cost = (longint'(s_aw.len) + 1) * AW_BEAT + T_B;
        ar_perm = (ar_cost * 256 <= tok_ar);
        aw_room = (outst < MAX_WR);
        aw_perm = aw_room && (aw_cost * 256 <= tok_aw);
        w_perm  = (outst != 0);
        check_val("m_arvalid", s_arvalid & ar_perm, m_arvalid);
        check_val("s_arready", m_arready & ar_perm, s_arready);
        check_val("m_awvalid", s_awvalid & aw_perm, m_awvalid);
        check_val("s_awready", m_awready & aw_perm, s_awready);
        check_val("m_wvalid", s_wvalid & w_perm, m_wvalid);
        check_val("s_wready", m_wready & w_perm, s_wready);
        check_val("m_ar", s_ar, m_ar);
        check_val("m_aw", s_aw, m_aw);
        check_val("m_w", s_w, m_w);
        check_val("s_b", m_b, s_b);
        check_val("s_bvalid", m_bvalid, s_bvalid);
        check_val("m_bready", s_bready, m_bready);
        check_val("s_r", m_r, s_r);
        check_val("s_rvalid", m_rvalid, s_rvalid);
        check_val("m_rready", s_rready, m_rready);
        // Model update for the rising edge
        aw_fwd  = s_awvalid & aw_room;
        ar_take = s_arvalid & m_arready & ar_perm;
        aw_take = aw_fwd & m_awready & aw_perm;
        w_end   = s_wvalid & m_wready & w_perm & s_w.last;
        tok_ar  = bucket_step(tok_ar, longint'(ar_init_tokens) * 256, ar_upd_tokens,
                              s_arvalid, m_arready, ar_take ? ar_cost * 256 : 0);
        tok_aw  = bucket_step(tok_aw, longint'(aw_init_tokens) * 256, aw_upd_tokens,
                              aw_fwd, m_awready, aw_take ? aw_cost * 256 : 0);
        if (aw_take && !w_end) begin
            outst++;
        end else if (!aw_take && w_end) begin
            outst--;
        end
        // Downstream traffic as the slave sees it
        if (m_arvalid && m_arready) begin
            acc_cnt++;
            cost_sum += ar_cost;
        end
        if (m_awvalid && m_awready) begin
            acc_cnt++;
            cost_sum += aw_cost;
        end
        if (m_wvalid && m_wready) begin
            burst_beats++;
            if (m_w.last) begin
                check_val("W beats in burst", wq[0] + 1, burst_beats);
                burst_beats = 0;
            end
        end
        // Master bookkeeping
        if ((s_arvalid && s_arready) || (s_awvalid && s_awready)) begin
            req_on = 1'b0;
        end
        if (s_wvalid && s_wready) begin
            w_fresh = 1'b1;
            if (s_w.last) begin
                void'(wq.pop_front());
                w_beat = 0;
            end else begin
                w_beat++;
            end
        end
        @(negedge aclk);
    endtask

    task automatic run_test(input int idx);
        int cyc;
        cur_kind       = tests[idx][0];
        cur_chan       = tests[idx][1];
        cur_len        = tests[idx][2];
        cur_nreq       = tests[idx][3];
        cur_window     = tests[idx][6];
        ar_init_tokens = tests[idx][4];
        aw_init_tokens = tests[idx][4];
        ar_upd_tokens  = tests[idx][5];
        aw_upd_tokens  = tests[idx][5];
        apply_reset();
        for (cyc = 0; cyc < cur_window; cyc++) begin
            step_cycle(cyc);
        end
        check_val("accepted requests", tests[idx][7], acc_cnt);
        // Cost taken never beats initial credit plus refill
        assert (cost_sum * 256 <= longint'(tests[idx][4]) * 256
                + longint'(tests[idx][5]) * cur_window) else begin
            other_errs++;
            $display("Test %0d let through more cost than its tokens allow", idx);
        end
    endtask

    // Watchdog sized from the test windows
    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int fd;
        int code;
        int i;
        int j;
        int cycles;
        int vals[8];
        string line;
        int seed_val;
        seed_val   = $urandom(32'h69269432);
        mism_errs  = 0;
        other_errs = 0;
        n_tests    = 0;
        cycles     = 0;
        aresetn    = 1'b0;
        drive_idle();
        ar_init_tokens = '0;
        aw_init_tokens = '0;
        ar_upd_tokens  = '0;
        aw_upd_tokens  = '0;
        fd = $fopen("bw_shaper_tests.txt", "r");
        assert (fd != 0) else begin
            other_errs++;
            $display("Cannot open bw_shaper_tests.txt, no tests run");
        end
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                // Header and blank lines do not parse as eight numbers
                code = $sscanf(line, "%d %d %d %d %d %d %d %d", vals[0], vals[1],
                               vals[2], vals[3], vals[4], vals[5], vals[6], vals[7]);
                if (code == 8) begin
                    for (j = 0; j < 8; j++) begin
                        tests[n_tests][j] = vals[j];
                    end
                    cycles += vals[6] + 4;
                    n_tests++;
                end
            end
            $fclose(fd);
        end
        watchdog_ns = (cycles + 200) * 4;
        @(negedge aclk);
        for (i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("Errors: %0d mismatches, %0d other failures", mism_errs, other_errs);
        if (mism_errs == 0 && other_errs == 0 && n_tests > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
axi_pkg.sv
shaper_pkg.sv
ax_token_shaper.sv
write_tracker.sv
axi_bw_shaper.sv
tb_axi_bw_shaper.sv

// ==== bw_shaper_tests.txt ====
# kind (0 always ready, 1 random ready, 2 W stalled first half) chan (0 read, 1 write)
# len nreq init_tokens rate_1.8 window_cycles expected_accepts
0 0 0 4 64 0 10 4
0 0 3 2 32 0 20 0
0 1 1 2 40 0 20 0
0 0 0 10 16 256 40 3
0 0 1 5 32 128 70 2
0 1 0 5 100 0 30 3
0 1 3 3 200 256 40 3
2 1 0 10 1000 256 40 10
1 0 1 4 64 128 300 4
1 1 1 4 100 128 300 4
0 0 255 2 4096 0 10 1
